// ==== addr_port/addr_port.sv ====
// VRAM address port: address register, step code and signed step table
`timescale 1ns/1ns
`include "vram_settings.svh"

module addr_port (
    input  logic                       clk,
    input  logic                       reset,
    input  vram_addr_pkg::port_cmd_t   cmd,
    output vram_addr_pkg::port_state_t state
);
    import vram_addr_pkg::*;

    logic [`STEP_W-1:0] step_mag;
    logic [`STEP_W-1:0] step_val;
    vram_addr_t         step_ext;
    vram_addr_t         addr_next;

    //////////////////////////////////////////////////////////////////////
    // Step table
    //////////////////////////////////////////////////////////////////////

    // Codes 1 to 10 are powers of two, 11 up are row pitches
    always_comb begin
        case (state.incr)
            0:  step_mag = `STEP_W'(0);
            1:  step_mag = `STEP_W'(1);
            2:  step_mag = `STEP_W'(2);
            3:  step_mag = `STEP_W'(4);
            4:  step_mag = `STEP_W'(8);
            5:  step_mag = `STEP_W'(16);
            6:  step_mag = `STEP_W'(32);
            7:  step_mag = `STEP_W'(64);
            8:  step_mag = `STEP_W'(128);
            9:  step_mag = `STEP_W'(256);
            10: step_mag = `STEP_W'(512);
            11: step_mag = `STEP_W'(40);
            12: step_mag = `STEP_W'(80);
            13: step_mag = `STEP_W'(160);
            14: step_mag = `STEP_W'(320);
            15: step_mag = `STEP_W'(640);
        endcase
    end

    assign step_val = state.decr ? -step_mag : step_mag;

    // Sign extend so a decrement wraps below zero
    assign step_ext = {{(`VRAM_ADDR_W - `STEP_W){step_val[`STEP_W-1]}}, step_val};

    //////////////////////////////////////////////////////////////////////
    // Address update
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_next = state.addr;
        if (cmd.step) begin
            addr_next = state.addr + step_ext;
        end else begin
            if (cmd.set_low) begin
                addr_next[`BYTE_W-1:0] = cmd.wr_data;
            end
            if (cmd.set_mid) begin
                addr_next[2*`BYTE_W-1:`BYTE_W] = cmd.wr_data;
            end
            if (cmd.set_high) begin
                addr_next[2*`BYTE_W] = cmd.wr_data[0];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= '0;
        end else begin
            state.addr <= addr_next;
            // High byte also carries the step code and direction
            if (cmd.set_high) begin
                state.incr <= cmd.wr_data[`BYTE_W-1:`BYTE_W-`STEP_CODE_W];
                state.decr <= cmd.wr_data[`BYTE_W-`STEP_CODE_W-1];
            end
        end
    end

endmodule

// ==== common/vram_addr_pkg.sv ====
// Shared VRAM address types: register and port enums, host, port and bus structs
`include "vram_settings.svh"

package vram_addr_pkg;

    typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;
    typedef logic [`BYTE_W-1:0]      byte_t;

    typedef enum logic [`REG_ADDR_W-1:0] {
        REG_ADDR_L = `REG_OFF_ADDR_L,
        REG_ADDR_M = `REG_OFF_ADDR_M,
        REG_ADDR_H = `REG_OFF_ADDR_H,
        REG_DATA0  = `REG_OFF_DATA0,
        REG_DATA1  = `REG_OFF_DATA1
    } reg_addr_e;

    typedef enum logic {
        PORT_0 = 1'b0,
        PORT_1 = 1'b1
    } vram_port_e;

    // One host bus cycle, read and write are single-cycle strobes
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`REG_ADDR_W-1:0] reg_addr;
        byte_t                  wr_data;
    } host_access_t;

    typedef struct packed {
        logic  set_low;
        logic  set_mid;
        logic  set_high;
        logic  step;
        byte_t wr_data;
    } port_cmd_t;

    typedef struct packed {
        vram_addr_t              addr;
        logic [`STEP_CODE_W-1:0] incr;
        logic                    decr;
    } port_state_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        vram_port_e port;
        byte_t      wr_data;
    } data_req_t;

    typedef struct packed {
        logic       do_access;
        logic       write;
        vram_addr_t addr;
        byte_t      wr_data;
    } vram_bus_t;

endpackage

// ==== common/vram_settings.svh ====
// VRAM address widths, step widths and host register offsets
`ifndef VRAM_SETTINGS_SVH
`define VRAM_SETTINGS_SVH

// Bus and register widths
`define VRAM_ADDR_W    17
`define BYTE_W         8
`define STEP_CODE_W    4
`define STEP_W         11
`define REG_ADDR_W     5

// Host register window offsets
`define REG_OFF_ADDR_L 0
`define REG_OFF_ADDR_M 1
`define REG_OFF_ADDR_H 2
`define REG_OFF_DATA0  3
`define REG_OFF_DATA1  4

`endif

// ==== compile.f ====
+incdir+common
common/vram_addr_pkg.sv
addr_port/addr_port.sv
verilog/reg_decode.sv
verilog/vram_access.sv
verilog/addr_data.sv
verif/addr_data_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the address and data block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=addr_data_sim

verilator --binary --timing -f compile.f --top-module addr_data_tb --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "Result: passed"
    exit 0
fi
echo "Result: failed"
exit 1

// ==== verif/addr_data_cases.txt ====
# op(1 wr/0 rd) reg sel data count | exp addr0 addr1 data0 data1 bus_write_addr
# Registers 0 ADDR_L, 1 ADDR_M, 2 ADDR_H, 3 DATA0, 4 DATA1, all fields in hex
1 0 0 34 1 00034 00000 34 00 00000
1 1 0 12 1 01234 00000 26 00 00000
1 0 1 78 1 01234 00078 26 78 00000
1 1 1 56 1 01234 05678 26 2e 00000
1 2 0 11 1 11234 05678 27 2e 00000
0 3 0 00 1 11235 05678 26 2e 00000
1 2 1 20 1 11235 05678 26 2e 00000
0 4 0 00 1 11235 0567a 26 2c 00000
1 2 0 b0 1 01235 0567a 27 2c 00000
0 3 1 00 1 0125d 0567a 4f 2c 00000
1 2 0 f0 1 0125d 0567a 4f 2c 00000
0 3 0 00 1 014dd 0567a c9 2c 00000
1 2 0 d0 1 014dd 0567a c9 2c 00000
0 3 0 00 1 0157d 0567a 68 2c 00000
1 2 0 c8 1 0157d 0567a 68 2c 00000
0 3 0 00 1 0152d 0567a 38 2c 00000
1 0 0 03 1 01503 0567a 16 2c 00000
1 1 0 00 1 00003 0567a 03 2c 00000
1 2 0 48 1 00003 0567a 03 2c 00000
0 3 0 00 1 1fffb 0567a 05 2c 00000
1 2 0 a1 1 1fffb 0567a 05 2c 00000
0 3 0 00 1 001fb 0567a fa 2c 00000
1 4 0 5a 1 001fb 0567c fa 2a 0567a
1 2 1 39 1 001fb 1567c fa 2b 00000
1 4 1 a5 1 001fb 15678 fa 2f 1567c
1 2 0 10 1 001fb 15678 fa 2f 00000
0 3 0 00 3 001fe 15678 ff 2f 00000
0 4 0 00 4 001fe 15668 ff 3f 00000

// ==== verif/addr_data_tb.sv ====
// Testbench for the address and data block with clock, VRAM model, case reader and compare tasks
`timescale 1ns/1ns
`include "vram_settings.svh"

module addr_data_tb;
    import vram_addr_pkg::*;

    localparam int IDLE_CYCLES  = 4;
    localparam int IDLE_TIMEOUT = 50;

    logic         clk;
    logic         reset;
    host_access_t host;
    logic         addr_select;
    byte_t        vram_rddata;
    port_state_t  port_0;
    port_state_t  port_1;
    byte_t        data0;
    byte_t        data1;
    vram_bus_t    bus;

    // Last host write request seen on the VRAM bus
    vram_bus_t    last_write;
    int           write_count;

    addr_data u_dut (
        .clk         (clk),
        .reset       (reset),
        .host        (host),
        .addr_select (addr_select),
        .vram_rddata (vram_rddata),
        .port_0      (port_0),
        .port_1      (port_1),
        .data0       (data0),
        .data1       (data1),
        .bus         (bus)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // VRAM model
    //////////////////////////////////////////////////////////////////////

    function automatic byte_t model_byte(input vram_addr_t addr);
        return addr[7:0] ^ addr[15:8] ^ {7'b0, addr[16]};
    endfunction

    // Bus sampled mid-cycle and read byte returned just after the next edge
    initial begin
        logic       rd_pending;
        vram_addr_t rd_addr;
        forever begin
            @(negedge clk);
            rd_pending = bus.do_access && !bus.write;
            rd_addr    = bus.addr;
            if (bus.do_access && bus.write) begin
                last_write  = bus;
                write_count = write_count + 1;
            end
            @(posedge clk);
            #1;
            if (rd_pending) begin
                vram_rddata = model_byte(rd_addr);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_addr(input string name, input vram_addr_t actual,
                              input vram_addr_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %05h, expected %05h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %02h, expected %02h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bus(input string name, input vram_bus_t actual,
                             input vram_bus_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %b/%b/%05h/%02h, expected %b/%b/%05h/%02h",
                     $time, name, actual.do_access, actual.write, actual.addr,
                     actual.wr_data, expected.do_access, expected.write, expected.addr,
                     expected.wr_data);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host stimulus and waits
    //////////////////////////////////////////////////////////////////////

    // Strobe held for count cycles gives count back-to-back accesses
    task automatic apply_strobes(input logic wr, input logic [`REG_ADDR_W-1:0] reg_off,
                                 input logic sel, input byte_t data, input int count);
        @(posedge clk);
        #1;
        host.read     = !wr;
        host.write    = wr;
        host.reg_addr = reg_off;
        host.wr_data  = data;
        addr_select   = sel;
        repeat (count) begin
            @(posedge clk);
            #1;
        end
        host.read  = 1'b0;
        host.write = 1'b0;
    endtask

    task automatic wait_bus_idle(input int case_no);
        int idle;
        int cycles;
        idle   = 0;
        cycles = 0;
        while (idle < IDLE_CYCLES) begin
            @(negedge clk);
            cycles = cycles + 1;
            idle   = bus.do_access ? 0 : idle + 1;
            if (cycles > IDLE_TIMEOUT) begin
                $display("Timeout: VRAM bus did not stay idle after case %0d", case_no);
                abort_run();
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int        fd;
        int        n;
        int        case_no;
        int        writes_before;
        int        op;
        int        reg_off;
        int        sel;
        int        wr_byte;
        int        count;
        int        exp_a0;
        int        exp_a1;
        int        exp_d0;
        int        exp_d1;
        int        exp_bus;
        int        data_write;
        string     line;
        vram_bus_t exp_write;
        byte_t     prev_d0;
        byte_t     prev_d1;

        reset       = 1'b1;
        host        = '0;
        addr_select = 1'b0;
        vram_rddata = '0;
        last_write  = '0;
        write_count = 0;
        case_no     = 0;
        prev_d0     = '0;
        prev_d1     = '0;
        void'($urandom(32'h8707_f022));
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // State straight out of reset
        check_addr("port_0.addr", port_0.addr, '0);
        check_addr("port_1.addr", port_1.addr, '0);
        check_byte("port_0.incr", byte_t'({port_0.incr, 3'b0, port_0.decr}), 8'h00);
        check_byte("port_1.incr", byte_t'({port_1.incr, 3'b0, port_1.decr}), 8'h00);
        check_byte("data0", data0, 8'h00);
        check_byte("data1", data1, 8'h00);
        check_bus("bus", bus, '0);

        fd = $fopen("verif/addr_data_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verif/addr_data_cases.txt");
            abort_run();
        end

        while ($fgets(line, fd) != 0) begin
            if (line.len() <= 1 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", op, reg_off, sel, wr_byte,
                        count, exp_a0, exp_a1, exp_d0, exp_d1, exp_bus);
            if (n != 10) begin
                $display("Malformed line in the case file: %s", line);
                abort_run();
            end
            case_no = case_no + 1;
            data_write = (op != 0 && (reg_off == `REG_OFF_DATA0 || reg_off == `REG_OFF_DATA1))
                         ? 1 : 0;
            last_write    = '0;
            writes_before = write_count;

            apply_strobes(op != 0, reg_off[`REG_ADDR_W-1:0], sel != 0, byte_t'(wr_byte), count);

            // One cycle before the result is due the DATA registers hold their old bytes
            repeat (2) @(posedge clk);
            #1;
            if (count == 1) begin
                check_byte("data0", data0, prev_d0);
                check_byte("data1", data1, prev_d1);
            end

            // DATA registers settle 3 cycles after the last strobe
            @(posedge clk);
            #1;
            check_byte("data0", data0, byte_t'(exp_d0));
            check_byte("data1", data1, byte_t'(exp_d1));

            wait_bus_idle(case_no);
            check_addr("port_0.addr", port_0.addr, vram_addr_t'(exp_a0));
            check_addr("port_1.addr", port_1.addr, vram_addr_t'(exp_a1));
            check_byte("data0", data0, byte_t'(exp_d0));
            check_byte("data1", data1, byte_t'(exp_d1));
            if (write_count - writes_before != data_write * count) begin
                $display("Case %0d expected %0d host writes on the VRAM bus but saw %0d",
                         case_no, data_write * count, write_count - writes_before);
                abort_run();
            end
            if (data_write != 0) begin
                exp_write.do_access = 1'b1;
                exp_write.write     = 1'b1;
                exp_write.addr      = vram_addr_t'(exp_bus);
                exp_write.wr_data   = byte_t'(wr_byte);
                check_bus("bus write", last_write, exp_write);
            end
            prev_d0 = byte_t'(exp_d0);
            prev_d1 = byte_t'(exp_d1);

            repeat (int'($urandom % 4)) @(posedge clk);
        end
        $fclose(fd);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verilog/addr_data.sv ====
// Address and data register block top: decode, two address ports, VRAM sequencer
`timescale 1ns/1ns

module addr_data (
    input  logic                       clk,
    input  logic                       reset,
    input  vram_addr_pkg::host_access_t host,
    input  logic                       addr_select,
    input  vram_addr_pkg::byte_t       vram_rddata,
    output vram_addr_pkg::port_state_t port_0,
    output vram_addr_pkg::port_state_t port_1,
    output vram_addr_pkg::byte_t       data0,
    output vram_addr_pkg::byte_t       data1,
    output vram_addr_pkg::vram_bus_t   bus
);
    import vram_addr_pkg::*;

    port_cmd_t cmd_0;
    port_cmd_t cmd_1;
    data_req_t data_req;

    //////////////////////////////////////////////////////////////////////
    // Register decode
    //////////////////////////////////////////////////////////////////////

    reg_decode u_reg_decode (
        .host        (host),
        .addr_select (addr_select),
        .cmd_0       (cmd_0),
        .cmd_1       (cmd_1),
        .data_req    (data_req)
    );

    //////////////////////////////////////////////////////////////////////
    // Address ports
    //////////////////////////////////////////////////////////////////////

    addr_port u_port_0 (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_0),
        .state (port_0)
    );

    addr_port u_port_1 (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_1),
        .state (port_1)
    );

    //////////////////////////////////////////////////////////////////////
    // VRAM access and fetch-ahead
    //////////////////////////////////////////////////////////////////////

    vram_access u_vram_access (
        .clk         (clk),
        .reset       (reset),
        .data_req    (data_req),
        .cmd_0       (cmd_0),
        .cmd_1       (cmd_1),
        .state_0     (port_0),
        .state_1     (port_1),
        .vram_rddata (vram_rddata),
        .bus         (bus),
        .data0       (data0),
        .data1       (data1)
    );

endmodule

// ==== verilog/reg_decode.sv ====
// Host register decode into per-port commands and a DATA access request
`timescale 1ns/1ns

module reg_decode (
    input  vram_addr_pkg::host_access_t host,
    input  logic                        addr_select,
    output vram_addr_pkg::port_cmd_t    cmd_0,
    output vram_addr_pkg::port_cmd_t    cmd_1,
    output vram_addr_pkg::data_req_t    data_req
);
    import vram_addr_pkg::*;

    reg_addr_e reg_sel;
    logic      data_access;

    assign reg_sel     = reg_addr_e'(host.reg_addr);
    assign data_access = host.read | host.write;

    always_comb begin
        cmd_0            = '0;
        cmd_1            = '0;
        data_req         = '0;
        cmd_0.wr_data    = host.wr_data;
        cmd_1.wr_data    = host.wr_data;
        data_req.wr_data = host.wr_data;
        data_req.write   = host.write;

        case (reg_sel)
            // Address bytes go to the port picked by the select level
            REG_ADDR_L: begin
                cmd_0.set_low = host.write & ~addr_select;
                cmd_1.set_low = host.write & addr_select;
            end
            REG_ADDR_M: begin
                cmd_0.set_mid = host.write & ~addr_select;
                cmd_1.set_mid = host.write & addr_select;
            end
            REG_ADDR_H: begin
                cmd_0.set_high = host.write & ~addr_select;
                cmd_1.set_high = host.write & addr_select;
            end
            // Data reads and writes both step their own port
            REG_DATA0: begin
                cmd_0.step     = data_access;
                data_req.valid = data_access;
                data_req.port  = PORT_0;
            end
            REG_DATA1: begin
                cmd_1.step     = data_access;
                data_req.valid = data_access;
                data_req.port  = PORT_1;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/vram_access.sv ====
// VRAM bus sequencer: host write pass-through, fetch-ahead reads, DATA0/DATA1 capture
`timescale 1ns/1ns

module vram_access (
    input  logic                       clk,
    input  logic                       reset,
    input  vram_addr_pkg::data_req_t   data_req,
    input  vram_addr_pkg::port_cmd_t   cmd_0,
    input  vram_addr_pkg::port_cmd_t   cmd_1,
    input  vram_addr_pkg::port_state_t state_0,
    input  vram_addr_pkg::port_state_t state_1,
    input  vram_addr_pkg::byte_t       vram_rddata,
    output vram_addr_pkg::vram_bus_t   bus,
    output vram_addr_pkg::byte_t       data0,
    output vram_addr_pkg::byte_t       data1
);
    import vram_addr_pkg::*;

    logic       change_0;
    logic       change_1;
    logic       fetch_ahead;
    vram_port_e fetch_port;
    // Port of the read on the bus, then of the byte coming back
    vram_port_e read_port;
    vram_port_e save_port;
    logic       save_result;
    vram_bus_t  bus_next;

    assign change_0 = cmd_0.set_low | cmd_0.set_mid | cmd_0.set_high | cmd_0.step;
    assign change_1 = cmd_1.set_low | cmd_1.set_mid | cmd_1.set_high | cmd_1.step;

    //////////////////////////////////////////////////////////////////////
    // Next bus request
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bus_next           = bus;
        bus_next.do_access = 1'b0;
        bus_next.write     = 1'b0;

        // Host write uses the address from before the step
        if (data_req.valid && data_req.write) begin
            bus_next.do_access = 1'b1;
            bus_next.write     = 1'b1;
            bus_next.addr      = (data_req.port == PORT_1) ? state_1.addr : state_0.addr;
            bus_next.wr_data   = data_req.wr_data;
        end

        // Fetch-ahead takes the bus over a write in the same cycle
        if (fetch_ahead) begin
            bus_next.do_access = 1'b1;
            bus_next.write     = 1'b0;
            bus_next.addr      = (fetch_port == PORT_1) ? state_1.addr : state_0.addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pipeline registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus         <= '0;
            fetch_ahead <= 1'b0;
            save_result <= 1'b0;
            data0       <= '0;
            data1       <= '0;
        end else begin
            bus         <= bus_next;
            fetch_ahead <= change_0 | change_1;
            // VRAM byte is valid the cycle after the read request
            save_result <= bus.do_access & ~bus.write;
            if (save_result && save_port == PORT_0) begin
                data0 <= vram_rddata;
            end
            if (save_result && save_port == PORT_1) begin
                data1 <= vram_rddata;
            end
        end
    end

    // Port tags follow the read through bus and capture stages
    always_ff @(posedge clk) begin
        if (change_0) begin
            fetch_port <= PORT_0;
        end else if (change_1) begin
            fetch_port <= PORT_1;
        end
        if (fetch_ahead) begin
            read_port <= fetch_port;
        end
        save_port <= read_port;
    end

endmodule
